// File: filelist.f
verilog/rv_isa_pkg.sv
verilog/alu_pkg.sv
verilog/exec_if.sv
verilog/regfile.sv
verilog/shift_rla.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/alu_core.sv
sim/clk_gen.sv
sim/alu_core_properties.sv
sim/alu_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute path simulation with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module alu_core_tb -f filelist.f -o valu_core_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/valu_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
	exit 0
fi
exit 1

// File: sim/alu_core_tb.sv
/* Execute path testbench
   Random OP/OP-IMM stream against a register model, checked at each falling edge */
`timescale 1ns/100ps

module alu_core_tb;

	// Instructions issued per test
	localparam int N_INSTR = 31 + 300 + 200 + 200 + 24 + 150;
	localparam int LIMIT   = N_INSTR * 2 + 100;

	logic        clk;
	logic        rst;
	logic        instr_valid;
	logic [31:0] instr;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	logic        wb_zero;
	logic        illegal;

	integer      seed = 81;
	int          cyc = 0;
	int          errors = 0;
	int          test_err = 0;
	int          checks = 0;
	logic [31:0] regs [32];          // Architectural model
	logic [4:0]  last_rd = '0;
	int          q_due [$];          // Expected outputs, in order
	logic [1:0]  q_kind [$];         // 1 writeback, 2 illegal
	logic [4:0]  q_rd [$];
	logic [31:0] q_data [$];

	clk_gen #(.PERIOD(10), .RST_CYCLES(8)) clk_gen_inst (.clk, .rst);

	alu_core #(.W_DATA(32), .W_SHAMT(5)) alu_core_inst (
		.clk, .rst, .instr_valid, .instr,
		.wb_valid, .wb_rd, .wb_data, .wb_zero, .illegal
	);

	task automatic note_error();
		errors++;
		test_err++;
	endtask

	// RV32I semantics for one instruction, pushes the expected output
	task automatic model_issue(input logic [31:0] ins);
		logic [6:0]  opc;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] sra_val;
		logic        is_op;
		logic        shift;
		logic        legal;
		opc   = ins[6:0];
		rd    = ins[11:7];
		f3    = ins[14:12];
		f7    = ins[31:25];
		is_op = (opc == rv_isa_pkg::OPC_OP);
		shift = (f3 == 3'd1) || (f3 == 3'd5);
		if (is_op)
			legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
		else if (opc == rv_isa_pkg::OPC_OP_IMM)
			legal = !shift || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
		else
			legal = 1'b0;
		a = regs[ins[19:15]];
		b = is_op ? regs[ins[24:20]] :
			shift ? {27'b0, ins[24:20]} : {{20{ins[31]}}, ins[31:20]};
		sra_val = $signed(a) >>> b[4:0]; // Arithmetic, own statement keeps it signed
		case (f3)
			3'd0: r = (is_op && f7[5]) ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'b0, $signed(a) < $signed(b)};
			3'd3: r = {31'b0, a < b};
			3'd4: r = a ^ b;
			3'd5: r = f7[5] ? sra_val : a >> b[4:0];
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		q_due.push_back(cyc + 2); // Sampled next edge, shown one edge later
		q_kind.push_back(legal ? 2'd1 : 2'd2);
		q_rd.push_back(rd);
		q_data.push_back(r);
		if (legal && rd != 5'd0) regs[rd] = r; // x0 never stored
	endtask

	task automatic issue(input logic [31:0] ins);
		@(posedge clk);
		instr       <= ins;
		instr_valid <= 1'b1;
		model_issue(ins);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		instr       <= $random(seed); // Garbage while invalid
		instr_valid <= 1'b0;
	endtask

	task automatic drain_and_report(input string name, input int n);
		while (q_due.size() != 0) idle_cycle();
		idle_cycle();
		$display("test %-28s %4d instr, %0d errors", name, n, test_err);
		test_err = 0;
	endtask

	// Lowest register whose model value is negative, x0 if none
	function automatic logic [4:0] negative_reg();
		logic [4:0] idx;
		idx = '0;
		for (int k = 31; k > 0; k--) begin
			if (regs[k][31]) idx = 5'(k);
		end
		return idx;
	endfunction

	// Legal OP, biased toward reading the previous destination
	task automatic gen_op(output logic [31:0] ins);
		logic [2:0] f3;
		logic [4:0] rs1;
		logic [4:0] rd;
		logic [6:0] f7;
		f3  = $random(seed);
		rs1 = $random(seed);
		rd  = $random(seed);
		f7  = ((f3 == 3'd0 || f3 == 3'd5) && $random(seed) % 2) ? 7'h20 : 7'h00;
		if (($random(seed) & 3) == 0) rs1 = last_rd; // Exercise bypass
		ins = {f7, 5'($random(seed)), rs1, f3, rd, rv_isa_pkg::OPC_OP};
		last_rd = rd;
	endtask

	// Legal OP-IMM, shamt < 0 means random
	task automatic gen_imm(input int f3_sel, input int shamt, output logic [31:0] ins);
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [4:0]  rd;
		f3  = (f3_sel < 0) ? 3'($random(seed)) : 3'(f3_sel);
		imm = $random(seed);
		rd  = $random(seed);
		if (f3 == 3'd1) imm[11:5] = 7'h00;
		if (f3 == 3'd5) imm[11:5] = ($random(seed) % 2) ? 7'h20 : 7'h00;
		if (shamt >= 0 && (f3 == 3'd1 || f3 == 3'd5)) imm[4:0] = shamt;
		ins = {imm, 5'($random(seed)), f3, rd, rv_isa_pkg::OPC_OP_IMM};
		last_rd = rd;
	endtask

	task automatic gen_illegal(output logic [31:0] ins);
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		ins = $random(seed);
		f3  = ins[14:12];
		f7  = ins[31:25];
		case (($random(seed) & 32'h7fff_ffff) % 3)
			0: begin // Foreign opcode
				opc = ins[6:0];
				while (opc == rv_isa_pkg::OPC_OP || opc == rv_isa_pkg::OPC_OP_IMM)
					opc = $random(seed);
				ins[6:0] = opc;
			end
			1: begin // OP with a funct7 that does not fit
				if (f7 == 7'h00) f7 = 7'h01;
				if (f7 == 7'h20) f7 = 7'h21;
				ins = {f7, ins[24:7], rv_isa_pkg::OPC_OP};
			end
			default: begin // Immediate shift with bad upper bits
				f3 = ins[0] ? 3'd1 : 3'd5;
				if (f7 == 7'h00 || f7 == 7'h20) f7 = 7'h60;
				ins = {f7, ins[24:15], f3, ins[11:7], rv_isa_pkg::OPC_OP_IMM};
			end
		endcase
	endtask

	// Output checker and cycle limit
	always @(negedge clk) begin
		if (!rst) begin
			checks++;
			if (q_due.size() != 0 && q_due[0] == cyc) begin
				if (q_kind[0] == 2'd1) begin
					assert (wb_valid === 1'b1 && illegal === 1'b0) else begin
						$display("Missing writeback for rd %0d at cycle %0d", q_rd[0], cyc);
						note_error();
					end
					assert (wb_rd === q_rd[0]) else begin
						$display("[ERROR] wb_rd exp %h got %h", q_rd[0], wb_rd);
						note_error();
					end
					assert (wb_data === q_data[0]) else begin
						$display("[ERROR] wb_data exp %h got %h", q_data[0], wb_data);
						note_error();
					end
					assert (wb_zero === (q_data[0] == 32'd0)) else begin
						$display("[ERROR] wb_zero exp %h got %h", q_data[0] == 32'd0, wb_zero);
						note_error();
					end
				end else begin
					assert (illegal === 1'b1 && wb_valid === 1'b0) else begin
						$display("Illegal instruction not flagged at cycle %0d", cyc);
						note_error();
					end
				end
				void'(q_due.pop_front());
				void'(q_kind.pop_front());
				void'(q_rd.pop_front());
				void'(q_data.pop_front());
			end else begin
				assert (wb_valid === 1'b0 && illegal === 1'b0) else begin
					$display("Unexpected output at cycle %0d", cyc);
					note_error();
				end
			end
		end
		if (cyc > LIMIT) begin
			$display("Run exceeded %0d cycles", LIMIT);
			$display("*** FAILED ***");
			$finish;
		end else begin
			cyc++;
		end
	end

	initial begin
		logic [31:0] ins;
		instr_valid = 1'b0;
		instr       = '0;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		wait (!rst);
		repeat (10) idle_cycle(); // Outputs stay quiet
		for (int i = 1; i < 32; i++) issue({12'($random(seed)), 5'd0, 3'd0, 5'(i), 7'h13});
		drain_and_report("1 reset and ADDI fill", 31);
		for (int i = 0; i < 300; i++) begin
			gen_op(ins);
			issue(ins);
		end
		drain_and_report("2 back-to-back OP", 300);
		for (int i = 0; i < 200; i++) begin
			if (i < 96) begin
				gen_imm((i < 32) ? 1 : 5, i % 32, ins); // SLLI, SRLI, SRAI sweeps
				if (i >= 32) ins[31:25] = (i < 64) ? 7'h00 : 7'h20;
				if (i >= 64) ins[19:15] = negative_reg(); // Sign fill on every shamt
			end else begin
				gen_imm(-1, -1, ins);
			end
			issue(ins);
		end
		drain_and_report("3 OP-IMM and shifts", 200);
		for (int i = 0; i < 200; i++) begin
			repeat (($random(seed) & 32'h7fff_ffff) % 4) idle_cycle();
			if ($random(seed) % 2) gen_op(ins);
			else gen_imm(-1, -1, ins);
			issue(ins);
		end
		drain_and_report("4 random gaps", 200);
		for (int i = 0; i < 12; i++) begin
			issue({12'($random(seed)), 5'($random(seed)), 3'd0, 5'd0, 7'h13}); // To x0
			issue({7'h00, 5'd0, 5'd0, 3'd6, 5'($random(seed)), 7'h33});        // Reads x0
		end
		drain_and_report("5 x0 writes", 24);
		for (int i = 0; i < 150; i++) begin
			if (i < 119) gen_illegal(ins);
			else ins = {7'h00, 5'd0, 5'(i - 118), 3'd6, 5'(i - 118), 7'h33}; // Read back
			issue(ins);
		end
		drain_and_report("6 illegal instructions", 150);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim/alu_core_properties.sv
/* Execute path properties
   Compare results, zero flag and writeback/illegal exclusivity */
`timescale 1ns/100ps

module alu_core_properties #(
	parameter W_DATA = 32
) (
	input logic              clk,
	input logic              rst,
	input logic              valid,
	input alu_pkg::alu_op_t  aluop,
	input logic [W_DATA-1:0] result,
	input logic              zero,
	input logic              wb_valid,
	input logic              illegal
);

	// Compares only ever produce 0 or 1
	assert property (@(posedge clk) disable iff (rst)
		valid && (aluop inside {alu_pkg::ALUOP_LT, alu_pkg::ALUOP_GE,
			alu_pkg::ALUOP_LTU, alu_pkg::ALUOP_GEU}) |-> result[W_DATA-1:1] == '0)
		else $error("compare result wider than one bit");

	assert property (@(posedge clk) disable iff (rst) valid |-> zero == ~|result)
		else $error("zero flag does not match result");

	assert property (@(posedge clk) disable iff (rst) !(wb_valid && illegal))
		else $error("writeback and illegal high together");

endmodule

bind alu_core alu_core_properties #(.W_DATA(W_DATA)) props_inst (
	.clk      (clk),
	.rst      (rst),
	.valid    (ex_bus.valid),
	.aluop    (alu_inst.aluop),
	.result   (alu_result),
	.zero     (alu_zero),
	.wb_valid (wb_valid),
	.illegal  (illegal)
);

// File: sim/clk_gen.sv
/* Testbench clock and reset
   Free-running clock, synchronous reset held for a fixed number of cycles */
`timescale 1ns/100ps

module clk_gen #(
	parameter PERIOD     = 10,
	parameter RST_CYCLES = 8
) (
	output logic clk,
	output logic rst
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0; // Released on a rising edge
	end

endmodule

// File: verilog/alu_core.sv
/* RV32I integer execute path
   Decode, register file, ALU and writeback stage */
`timescale 1ns/100ps

module alu_core #(
	parameter W_DATA  = 32,
	parameter W_SHAMT = 5
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             instr_valid,
	input  logic [31:0]                      instr,
	output logic                             wb_valid,
	output logic [rv_isa_pkg::W_REGADDR-1:0] wb_rd,
	output logic [W_DATA-1:0]                wb_data,
	output logic                             wb_zero,
	output logic                             illegal
);

	logic [rv_isa_pkg::W_REGADDR-1:0] rs1;
	logic [rv_isa_pkg::W_REGADDR-1:0] rs2;
	logic [W_DATA-1:0]                rd1;
	logic [W_DATA-1:0]                rd2;
	logic                             rf_we;
	logic                             illegal_q;
	logic [W_DATA-1:0]                alu_result;
	logic                             alu_zero;

	exec_if #(.W_DATA(W_DATA)) ex_bus ();

	// Write on the same edge as the writeback registers
	assign rf_we = ex_bus.valid && (ex_bus.rd != '0);

	regfile #(.W_DATA(W_DATA)) regfile_inst (
		.clk, .rst,
		.rs1, .rs2, .rd1, .rd2,
		.we (rf_we),
		.wa (ex_bus.rd),
		.wd (alu_result)
	);

	instr_decode #(.W_DATA(W_DATA)) instr_decode_inst (
		.clk, .rst, .instr_valid, .instr,
		.rs1, .rs2, .rd1, .rd2,
		.fwd_valid (ex_bus.valid), // Result of the op one slot ahead
		.fwd_rd    (ex_bus.rd),
		.fwd_data  (alu_result),
		.illegal_q,
		.ex        (ex_bus.producer)
	);

	alu #(.W_DATA(W_DATA), .W_SHAMT(W_SHAMT)) alu_inst (
		.aluop  (ex_bus.aluop),
		.op_a   (ex_bus.op_a),
		.op_b   (ex_bus.op_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			wb_valid <= ex_bus.valid;
			illegal  <= illegal_q; // Second stage of illegal
		end
	end

	always_ff @(posedge clk) begin
		if (ex_bus.valid) begin
			wb_rd   <= ex_bus.rd; // x0 results still shown here
			wb_data <= alu_result;
			wb_zero <= alu_zero;
		end
	end

endmodule

// File: verilog/instr_decode.sv
/* OP/OP-IMM decoder
   Builds ALU op and operands with bypass, registers them onto exec_if */
`timescale 1ns/100ps

module instr_decode #(
	parameter W_DATA = 32
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             instr_valid,
	input  logic [31:0]                      instr,
	output logic [rv_isa_pkg::W_REGADDR-1:0] rs1,
	output logic [rv_isa_pkg::W_REGADDR-1:0] rs2,
	input  logic [W_DATA-1:0]                rd1,
	input  logic [W_DATA-1:0]                rd2,
	input  logic                             fwd_valid,
	input  logic [rv_isa_pkg::W_REGADDR-1:0] fwd_rd,
	input  logic [W_DATA-1:0]                fwd_data,
	output logic                             illegal_q,
	exec_if.producer                         ex
);

	logic [6:0]                       opcode;
	logic [2:0]                       funct3;
	logic [6:0]                       funct7;
	logic [rv_isa_pkg::W_REGADDR-1:0] rd_idx;
	logic                             is_op;
	logic                             is_op_imm;
	logic                             f7_base;
	logic                             f7_alt;
	logic                             f7_bad;
	logic                             bad;
	logic                             imm_shift;
	alu_pkg::alu_op_t                 aluop_d;
	logic [W_DATA-1:0]                imm_i;
	logic [W_DATA-1:0]                imm_sh;
	logic [W_DATA-1:0]                src1;
	logic [W_DATA-1:0]                src2;
	logic [W_DATA-1:0]                op_b_d;

	// Field extraction
	assign opcode = instr[rv_isa_pkg::OPC_LSB +: 7];
	assign funct3 = instr[rv_isa_pkg::F3_LSB +: 3];
	assign funct7 = instr[rv_isa_pkg::F7_LSB +: 7];
	assign rd_idx = instr[rv_isa_pkg::RD_LSB +: rv_isa_pkg::W_REGADDR];
	assign rs1    = instr[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::W_REGADDR];
	assign rs2    = instr[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::W_REGADDR];

	assign is_op     = (opcode == rv_isa_pkg::OPC_OP);
	assign is_op_imm = (opcode == rv_isa_pkg::OPC_OP_IMM);
	assign f7_base   = (funct7 == rv_isa_pkg::F7_BASE);
	assign f7_alt    = (funct7 == rv_isa_pkg::F7_ALT);

	// funct3 to ALU op, plus funct7 legality per format
	always_comb begin
		aluop_d = alu_pkg::ALUOP_ADD;
		f7_bad  = 1'b0;
		case (funct3)
			rv_isa_pkg::F3_ADD_SUB: begin
				aluop_d = (is_op && f7_alt) ? alu_pkg::ALUOP_SUB : alu_pkg::ALUOP_ADD;
				f7_bad  = is_op && !f7_base && !f7_alt; // ADDI has no funct7
			end
			rv_isa_pkg::F3_SLL: begin
				aluop_d = alu_pkg::ALUOP_SLL;
				f7_bad  = !f7_base; // SLLI too
			end
			rv_isa_pkg::F3_SR: begin
				aluop_d = f7_alt ? alu_pkg::ALUOP_SRA : alu_pkg::ALUOP_SRL;
				f7_bad  = !f7_base && !f7_alt;
			end
			rv_isa_pkg::F3_SLT:  aluop_d = alu_pkg::ALUOP_LT;
			rv_isa_pkg::F3_SLTU: aluop_d = alu_pkg::ALUOP_LTU;
			rv_isa_pkg::F3_XOR:  aluop_d = alu_pkg::ALUOP_XOR;
			rv_isa_pkg::F3_OR:   aluop_d = alu_pkg::ALUOP_OR;
			default:             aluop_d = alu_pkg::ALUOP_AND; // F3_AND
		endcase
		// Remaining funct3 codes need funct7 zero in OP only
		if (funct3 != rv_isa_pkg::F3_ADD_SUB && funct3 != rv_isa_pkg::F3_SLL &&
			funct3 != rv_isa_pkg::F3_SR) begin
			f7_bad = is_op && !f7_base;
		end
	end

	assign bad = !(is_op || is_op_imm) || f7_bad;

	// Immediates, shamt goes in zero-extended
	assign imm_i  = {{(W_DATA-rv_isa_pkg::W_IMM_I){instr[31]}}, instr[31 -: rv_isa_pkg::W_IMM_I]};
	assign imm_sh = W_DATA'(instr[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::W_SHAMT_RV]);
	assign imm_shift = (funct3 == rv_isa_pkg::F3_SLL) || (funct3 == rv_isa_pkg::F3_SR);

	// Bypass from the op in execute, never for x0
	assign src1 = (fwd_valid && fwd_rd == rs1 && rs1 != '0) ? fwd_data : rd1;
	assign src2 = (fwd_valid && fwd_rd == rs2 && rs2 != '0) ? fwd_data : rd2;

	assign op_b_d = is_op ? src2 : (imm_shift ? imm_sh : imm_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			ex.valid  <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			ex.valid  <= instr_valid && !bad;
			illegal_q <= instr_valid && bad; // Exclusive with valid
		end
	end

	// Payload, only meaningful alongside valid
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex.aluop <= aluop_d;
			ex.op_a  <= src1;
			ex.op_b  <= op_b_d;
			ex.rd    <= rd_idx;
		end
	end

endmodule

// File: verilog/alu.sv
/* Integer ALU
   Add/sub, signed and unsigned compares, logic ops, shifts, zero flag */
`timescale 1ns/100ps

module alu #(
	parameter W_DATA  = 32,
	parameter W_SHAMT = 5
) (
	input  alu_pkg::alu_op_t  aluop,
	input  logic [W_DATA-1:0] op_a,
	input  logic [W_DATA-1:0] op_b,
	output logic [W_DATA-1:0] result,
	output logic              zero
);

	logic [W_DATA-1:0] sum;
	logic [W_DATA-1:0] diff;
	logic              borrow;   // Set when op_a < op_b unsigned
	logic              lt;       // Signed less-than
	logic              ltu;
	logic              shift_right;
	logic              shift_arith;
	logic [W_DATA-1:0] shift_dout;

	assign sum             = op_a + op_b;
	assign {borrow, diff}  = {1'b0, op_a} - {1'b0, op_b}; // Extra bit catches borrow
	assign ltu             = borrow;

	// Differing signs decide directly, else the difference sign does
	assign lt = (op_a[W_DATA-1] != op_b[W_DATA-1]) ? op_a[W_DATA-1] : diff[W_DATA-1];

	assign shift_right = (aluop == alu_pkg::ALUOP_SRL) || (aluop == alu_pkg::ALUOP_SRA);
	assign shift_arith = (aluop == alu_pkg::ALUOP_SRA);

	shift_rla #(
		.W_DATA  (W_DATA),
		.W_SHAMT (W_SHAMT)
	) shifter (
		.din         (op_a),
		.shamt       (op_b[W_SHAMT-1:0]), // Upper op_b bits ignored for shifts
		.right_nleft (shift_right),
		.arith       (shift_arith),
		.dout        (shift_dout)
	);

	always_comb begin
		case (aluop)
			alu_pkg::ALUOP_SUB: result = diff;
			alu_pkg::ALUOP_LT:  result = W_DATA'(lt);  // Compares give 0 or 1
			alu_pkg::ALUOP_GE:  result = W_DATA'(!lt);
			alu_pkg::ALUOP_LTU: result = W_DATA'(ltu);
			alu_pkg::ALUOP_GEU: result = W_DATA'(!ltu);
			alu_pkg::ALUOP_AND: result = op_a & op_b;
			alu_pkg::ALUOP_OR:  result = op_a | op_b;
			alu_pkg::ALUOP_XOR: result = op_a ^ op_b;
			alu_pkg::ALUOP_SRL,
			alu_pkg::ALUOP_SRA,
			alu_pkg::ALUOP_SLL: result = shift_dout; // Direction set above
			default:            result = sum;        // ADD and unused codes
		endcase
	end

	assign zero = ~|result;

endmodule

// File: verilog/shift_rla.sv
/* Barrel shifter, left/right and logical/arithmetic
   Single right shifter, left shifts go through bit reversal */
`timescale 1ns/100ps

module shift_rla #(
	parameter W_DATA  = 32,
	parameter W_SHAMT = 5
) (
	input  logic [W_DATA-1:0]  din,
	input  logic [W_SHAMT-1:0] shamt,
	input  logic               right_nleft,
	input  logic               arith,
	output logic [W_DATA-1:0]  dout
);

	function automatic logic [W_DATA-1:0] bit_rev(input logic [W_DATA-1:0] x);
		logic [W_DATA-1:0] r;
		for (int i = 0; i < W_DATA; i++) begin
			r[i] = x[W_DATA-1-i];
		end
		return r;
	endfunction

	logic              sext;                // Fill bit for vacated positions
	logic [W_DATA-1:0] stage [0:W_SHAMT];  // One entry per shift stage

	assign sext     = arith & right_nleft & din[W_DATA-1];
	assign stage[0] = right_nleft ? din : bit_rev(din); // Left becomes right

	// Stage i shifts by 2**i when its shamt bit is set
	for (genvar i = 0; i < W_SHAMT; i++) begin : g_stage
		assign stage[i+1] = shamt[i] ?
			{{(1 << i){sext}}, stage[i][W_DATA-1:(1 << i)]} : stage[i];
	end

	assign dout = right_nleft ? stage[W_SHAMT] : bit_rev(stage[W_SHAMT]); // Undo reversal

endmodule

// File: verilog/regfile.sv
/* Integer register file
   Two combinational reads, one synchronous write, x0 hardwired to zero */
`timescale 1ns/100ps

module regfile #(
	parameter W_DATA = 32
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [rv_isa_pkg::W_REGADDR-1:0] rs1,
	input  logic [rv_isa_pkg::W_REGADDR-1:0] rs2,
	output logic [W_DATA-1:0]                rd1,
	output logic [W_DATA-1:0]                rd2,
	input  logic                             we,
	input  logic [rv_isa_pkg::W_REGADDR-1:0] wa,
	input  logic [W_DATA-1:0]                wd
);

	localparam int N_REGS = 1 << rv_isa_pkg::W_REGADDR;

	// No storage behind x0
	logic [W_DATA-1:0] mem [1:N_REGS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < N_REGS; i++) begin
				mem[i] <= '0; // All registers read 0 after reset
			end
		end else if (we && wa != '0) begin
			mem[wa] <= wd; // Writes to x0 dropped
		end
	end

	// Same-edge write is not visible here, decoder bypasses it
	assign rd1 = (rs1 == '0) ? '0 : mem[rs1];
	assign rd2 = (rs2 == '0) ? '0 : mem[rs2];

endmodule

// File: verilog/exec_if.sv
/* Decode to execute bus
   One decoded operation per cycle, qualified by valid, no ready */
`timescale 1ns/100ps

interface exec_if #(
	parameter W_DATA = 32
);

	logic                                valid; // One-cycle qualifier
	alu_pkg::alu_op_t                    aluop;
	logic [W_DATA-1:0]                   op_a;  // rs1 value, bypassed
	logic [W_DATA-1:0]                   op_b;  // rs2 value or immediate
	logic [rv_isa_pkg::W_REGADDR-1:0]    rd;    // Destination index

	// Decoder side, all driven from its registers
	modport producer (
		output valid,
		output aluop,
		output op_a,
		output op_b,
		output rd
	);

	// Execute side, must take the op in its valid cycle
	modport consumer (
		input valid,
		input aluop,
		input op_a,
		input op_b,
		input rd
	);

endinterface

// File: verilog/alu_pkg.sv
/* ALU operation codes
   Shared by decoder, ALU and checks */
package alu_pkg;

	// Add comes first so it is the reset/default encoding
	typedef enum logic [3:0] {
		ALUOP_ADD = 4'h0,
		ALUOP_SUB = 4'h1,
		ALUOP_LT  = 4'h2, // Signed less-than
		ALUOP_GE  = 4'h3,
		ALUOP_LTU = 4'h4, // Unsigned less-than
		ALUOP_GEU = 4'h5,
		ALUOP_AND = 4'h6,
		ALUOP_OR  = 4'h7,
		ALUOP_XOR = 4'h8,
		ALUOP_SRL = 4'h9,
		ALUOP_SRA = 4'ha, // Right shift with sign fill
		ALUOP_SLL = 4'hb
	} alu_op_t;

	// Codes 4'hc..4'hf unused, ALU treats them as add

endpackage

// File: verilog/rv_isa_pkg.sv
/* RV32I ISA constants
   Opcodes, funct3/funct7 codes and register index width for the integer path */
package rv_isa_pkg;

	// Register index width, 32 architectural registers
	localparam int W_REGADDR = 5;

	// Major opcodes handled by the execute path
	localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate

	// funct3 field, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA, picked by funct7
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 values
	localparam logic [6:0] F7_BASE = 7'b0000000; // Plain op
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA/SRAI

	// Instruction field positions
	localparam int OPC_LSB = 0;
	localparam int RD_LSB  = 7;
	localparam int F3_LSB  = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_LSB  = 25;

	// Bits in the I-type immediate, and width of the RV32I shamt field
	localparam int W_IMM_I    = 12;
	localparam int W_SHAMT_RV = 5;

endpackage
